// ==== logic/bmc_macros.svh ====
`ifndef BMC_MACROS_SVH
`define BMC_MACROS_SVH

// ========================================
// widths.
// ========================================
`define BMC_ADDR_W        16
`define BMC_DATA_W        16
`define BMC_SAMPLE_W      12
`define BMC_CHAN_W        3
`define BMC_NUM_CHANNELS  8
`define BMC_NUM_IRQ       2

// ========================================
// address map, one window per slave.
// ========================================
`define BMC_NUM_SLAVES    4
`define BMC_SLV_SYSCONF   0
`define BMC_SLV_LEVCHK    1
`define BMC_SLV_IRQC      2
`define BMC_SLV_BUSMON    3

`define BMC_SYSCONF_BASE  16'h0000
`define BMC_LEVCHK_BASE   16'h0100
`define BMC_IRQC_BASE     16'h0200
`define BMC_BUSMON_BASE   16'h0300
`define BMC_REGION_SIZE   16

// register offsets within a window.
`define BMC_SYSCONF_ID_OFS     16'h0000
`define BMC_SYSCONF_REV_OFS    16'h0001
`define BMC_SYSCONF_CFG_OFS    16'h0002
`define BMC_LEVCHK_INRANGE_OFS 16'h0008
`define BMC_LEVCHK_STICKY_OFS  16'h0009
`define BMC_IRQC_PENDING_OFS   16'h0000
`define BMC_IRQC_MASK_OFS      16'h0001
`define BMC_BUSMON_ADDR_OFS    16'h0000
`define BMC_BUSMON_STATUS_OFS  16'h0001

// reset and identity values.
`define BMC_BOARD_ID      16'h0007
`define BMC_REV           16'h0102
`define BMC_SYSCFG_RESET  8'h01
`define BMC_THRESH_RESET  12'hFFF

`endif

// ==== logic/bmc_pkg.sv ====
`include "bmc_macros.svh"

package bmc_pkg;

  // ========================================
  // plain vector types.
  // ========================================
  typedef logic [`BMC_ADDR_W-1:0]       addr_t;
  typedef logic [`BMC_DATA_W-1:0]       data_t;
  typedef logic [`BMC_SAMPLE_W-1:0]     sample_t;
  typedef logic [`BMC_CHAN_W-1:0]       chan_t;
  typedef logic [`BMC_NUM_CHANNELS-1:0] chan_mask_t;

  // bit 0 is the level violation, bit 1 the bus memory violation.
  typedef logic [`BMC_NUM_IRQ-1:0]      irq_vec_t;

  // ========================================
  // bus and sample bundles.
  // ========================================
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    logic  err;
    data_t dat;
  } wb_rsp_t;

  typedef struct packed {
    logic    valid;
    chan_t   channel;
    sample_t result;
  } adc_sample_t;

endpackage

// ==== logic/wb_decoder.sv ====
`include "bmc_macros.svh"

module wb_decoder (
  input  logic                                   hard_reset,
  input  logic                                   gclk40,
  input  bmc_pkg::wb_req_t                       m_req_i,
  output bmc_pkg::wb_rsp_t                       m_rsp_o,
  output bmc_pkg::wb_req_t [`BMC_NUM_SLAVES-1:0] s_req_o,
  input  bmc_pkg::wb_rsp_t [`BMC_NUM_SLAVES-1:0] s_rsp_i,
  output logic                                   memv_o,
  output bmc_pkg::addr_t                         viol_addr_o,
  output logic                                   viol_we_o
);

  localparam bmc_pkg::addr_t SLAVE_BASE [`BMC_NUM_SLAVES] = '{
    `BMC_SYSCONF_BASE,
    `BMC_LEVCHK_BASE,
    `BMC_IRQC_BASE,
    `BMC_BUSMON_BASE
  };

  logic                                 strobe;
  logic                                 unmapped;
  logic                                 err_q;
  logic [`BMC_NUM_SLAVES-1:0]           sel;
  bmc_pkg::addr_t [`BMC_NUM_SLAVES-1:0] offset;
  logic                                 ack;
  bmc_pkg::data_t                       rdat;

  assign strobe = m_req_i.cyc && m_req_i.stb;

  // ========================================
  // window match and request fan-out.
  // ========================================
  // the subtraction wraps below the base, so one compare covers both ends.
  always_comb begin
    for (int i = 0; i < `BMC_NUM_SLAVES; i++) begin
      offset[i] = m_req_i.adr - SLAVE_BASE[i];
      sel[i]    = strobe && (offset[i] < bmc_pkg::addr_t'(`BMC_REGION_SIZE));
    end
  end

  always_comb begin
    for (int i = 0; i < `BMC_NUM_SLAVES; i++) begin
      s_req_o[i]     = m_req_i;
      s_req_o[i].stb = sel[i];
      s_req_o[i].adr = offset[i];
    end
  end

  // ========================================
  // response merge.
  // ========================================
  // idle slaves drive zero data, so a plain OR picks the active one.
  always_comb begin
    ack  = 1'b0;
    rdat = '0;
    for (int i = 0; i < `BMC_NUM_SLAVES; i++) begin
      ack  = ack | s_rsp_i[i].ack;
      rdat = rdat | s_rsp_i[i].dat;
    end
  end

  assign m_rsp_o = {ack, err_q, rdat};

  // unmapped strobe, answered here with err.
  assign unmapped = strobe && (sel == '0);

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      err_q <= 1'b0;
    end else begin
      err_q <= unmapped && !err_q;
    end
  end

  // violation details, held beside the err pulse.
  always_ff @(posedge gclk40) begin
    if (unmapped && !err_q) begin
      viol_addr_o <= m_req_i.adr;
      viol_we_o   <= m_req_i.we;
    end
  end

  assign memv_o = err_q;

  sel_onehot_a : assert property (
    @(posedge gclk40) disable iff (!hard_reset) $onehot0(sel)
  );

  ack_err_excl_a : assert property (
    @(posedge gclk40) disable iff (!hard_reset) !(m_rsp_o.ack && m_rsp_o.err)
  );

endmodule

// ==== logic/sys_config.sv ====
`include "bmc_macros.svh"

module sys_config (
  input  logic             hard_reset,
  input  logic             gclk40,
  input  bmc_pkg::wb_req_t req_i,
  output bmc_pkg::wb_rsp_t rsp_o,
  output logic [7:0]       sys_config_o
);

  logic           access;
  logic           ack_q;
  bmc_pkg::data_t rdat;
  bmc_pkg::data_t rdat_q;
  logic [7:0]     cfg_q;

  // one ack per strobe.
  assign access = req_i.cyc && req_i.stb && !ack_q;

  always_comb begin
    case (req_i.adr)
      `BMC_SYSCONF_ID_OFS:  rdat = `BMC_BOARD_ID;
      `BMC_SYSCONF_REV_OFS: rdat = `BMC_REV;
      `BMC_SYSCONF_CFG_OFS: rdat = {8'h00, cfg_q};
      default:              rdat = '0;
    endcase
  end

  // id and revision are fixed, writes there just get acked.
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      ack_q  <= 1'b0;
      rdat_q <= '0;
      cfg_q  <= `BMC_SYSCFG_RESET;
    end else begin
      ack_q  <= access;
      rdat_q <= access ? rdat : '0;
      if (access && req_i.we && (req_i.adr == `BMC_SYSCONF_CFG_OFS)) begin
        cfg_q <= req_i.dat[7:0];
      end
    end
  end

  assign rsp_o        = {ack_q, 1'b0, rdat_q};
  assign sys_config_o = cfg_q;

endmodule

// ==== logic/level_checker.sv ====
`include "bmc_macros.svh"

module level_checker (
  input  logic                 hard_reset,
  input  logic                 gclk40,
  input  bmc_pkg::wb_req_t     req_i,
  output bmc_pkg::wb_rsp_t     rsp_o,
  input  bmc_pkg::adc_sample_t adc_sample_i,
  output bmc_pkg::chan_mask_t  in_range_o,
  output logic                 viol_o
);

  logic                access;
  logic                ack_q;
  logic                thresh_sel;
  logic                over;
  bmc_pkg::data_t      rdat;
  bmc_pkg::data_t      rdat_q;
  bmc_pkg::sample_t    thresh_q [`BMC_NUM_CHANNELS];
  bmc_pkg::chan_mask_t in_range_q;
  bmc_pkg::chan_mask_t sticky_q;
  bmc_pkg::chan_mask_t hit;
  bmc_pkg::chan_mask_t clr;

  assign access     = req_i.cyc && req_i.stb && !ack_q;
  assign thresh_sel = req_i.adr < bmc_pkg::addr_t'(`BMC_NUM_CHANNELS);

  // ========================================
  // sample compare.
  // ========================================
  assign over = adc_sample_i.valid &&
                (adc_sample_i.result > thresh_q[adc_sample_i.channel]);
  assign hit  = over ? bmc_pkg::chan_mask_t'(1) << adc_sample_i.channel : '0;

  // write-one-to-clear on the sticky register.
  assign clr = (access && req_i.we && (req_i.adr == `BMC_LEVCHK_STICKY_OFS)) ?
               bmc_pkg::chan_mask_t'(req_i.dat) : '0;

  // ========================================
  // register read.
  // ========================================
  always_comb begin
    rdat = '0;
    if (thresh_sel) begin
      rdat = bmc_pkg::data_t'(thresh_q[bmc_pkg::chan_t'(req_i.adr)]);
    end else if (req_i.adr == `BMC_LEVCHK_INRANGE_OFS) begin
      rdat = bmc_pkg::data_t'(in_range_q);
    end else if (req_i.adr == `BMC_LEVCHK_STICKY_OFS) begin
      rdat = bmc_pkg::data_t'(sticky_q);
    end
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      ack_q      <= 1'b0;
      rdat_q     <= '0;
      in_range_q <= '1;
      sticky_q   <= '0;
      viol_o     <= 1'b0;
      for (int i = 0; i < `BMC_NUM_CHANNELS; i++) begin
        thresh_q[i] <= `BMC_THRESH_RESET;
      end
    end else begin
      ack_q  <= access;
      rdat_q <= access ? rdat : '0;
      viol_o <= over;
      // a new violation wins over a clear in the same cycle.
      sticky_q <= (sticky_q & ~clr) | hit;
      if (adc_sample_i.valid) begin
        in_range_q[adc_sample_i.channel] <= !over;
      end
      if (access && req_i.we && thresh_sel) begin
        thresh_q[bmc_pkg::chan_t'(req_i.adr)] <= req_i.dat[`BMC_SAMPLE_W-1:0];
      end
    end
  end

  assign rsp_o      = {ack_q, 1'b0, rdat_q};
  assign in_range_o = in_range_q;

  chan_range_a : assert property (
    @(posedge gclk40) disable iff (!hard_reset)
    adc_sample_i.valid |-> (int'(adc_sample_i.channel) < `BMC_NUM_CHANNELS)
  );

endmodule

// ==== logic/irq_controller.sv ====
`include "bmc_macros.svh"

module irq_controller (
  input  logic              hard_reset,
  input  logic              gclk40,
  input  bmc_pkg::wb_req_t  req_i,
  output bmc_pkg::wb_rsp_t  rsp_o,
  input  bmc_pkg::irq_vec_t src_i,
  output logic              irq_o
);

  logic              access;
  logic              ack_q;
  bmc_pkg::data_t    rdat;
  bmc_pkg::data_t    rdat_q;
  bmc_pkg::irq_vec_t pending_q;
  bmc_pkg::irq_vec_t mask_q;
  bmc_pkg::irq_vec_t clr;

  assign access = req_i.cyc && req_i.stb && !ack_q;

  assign clr = (access && req_i.we && (req_i.adr == `BMC_IRQC_PENDING_OFS)) ?
               bmc_pkg::irq_vec_t'(req_i.dat) : '0;

  always_comb begin
    case (req_i.adr)
      `BMC_IRQC_PENDING_OFS: rdat = bmc_pkg::data_t'(pending_q);
      `BMC_IRQC_MASK_OFS:    rdat = bmc_pkg::data_t'(mask_q);
      default:               rdat = '0;
    endcase
  end

  // ========================================
  // pending, mask and the output line.
  // ========================================
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      ack_q     <= 1'b0;
      rdat_q    <= '0;
      pending_q <= '0;
      mask_q    <= '0;
      irq_o     <= 1'b0;
    end else begin
      ack_q  <= access;
      rdat_q <= access ? rdat : '0;
      // sources set, write-one clears; a fresh pulse is never lost.
      pending_q <= (pending_q & ~clr) | src_i;
      if (access && req_i.we && (req_i.adr == `BMC_IRQC_MASK_OFS)) begin
        mask_q <= bmc_pkg::irq_vec_t'(req_i.dat);
      end
      irq_o <= |(pending_q & mask_q);
    end
  end

  assign rsp_o = {ack_q, 1'b0, rdat_q};

endmodule

// ==== logic/bus_monitor.sv ====
`include "bmc_macros.svh"

module bus_monitor (
  input  logic             hard_reset,
  input  logic             gclk40,
  input  bmc_pkg::wb_req_t req_i,
  output bmc_pkg::wb_rsp_t rsp_o,
  input  logic             memv_i,
  input  bmc_pkg::addr_t   viol_addr_i,
  input  logic             viol_we_i
);

  logic           access;
  logic           ack_q;
  logic           clear;
  logic           cap_valid_q;
  logic           cap_we_q;
  bmc_pkg::addr_t cap_addr_q;
  bmc_pkg::data_t rdat;
  bmc_pkg::data_t rdat_q;

  assign access = req_i.cyc && req_i.stb && !ack_q;
  assign clear  = access && req_i.we && (req_i.adr == `BMC_BUSMON_STATUS_OFS);

  always_comb begin
    case (req_i.adr)
      `BMC_BUSMON_ADDR_OFS:   rdat = cap_addr_q;
      `BMC_BUSMON_STATUS_OFS: rdat = {14'h0000, cap_we_q, cap_valid_q};
      default:                rdat = '0;
    endcase
  end

  // only the first violation is kept until software clears it.
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      ack_q       <= 1'b0;
      rdat_q      <= '0;
      cap_valid_q <= 1'b0;
      cap_we_q    <= 1'b0;
      cap_addr_q  <= '0;
    end else begin
      ack_q  <= access;
      rdat_q <= access ? rdat : '0;
      if (clear) begin
        cap_valid_q <= 1'b0;
      end else if (memv_i && !cap_valid_q) begin
        cap_valid_q <= 1'b1;
        cap_we_q    <= viol_we_i;
        cap_addr_q  <= viol_addr_i;
      end
    end
  end

  assign rsp_o = {ack_q, 1'b0, rdat_q};

endmodule

// ==== logic/bmc_top.sv ====
`include "bmc_macros.svh"

module bmc_top (
  input  logic                 hard_reset,
  input  logic                 gclk40,
  input  bmc_pkg::wb_req_t     wb_req_i,
  output bmc_pkg::wb_rsp_t     wb_rsp_o,
  input  bmc_pkg::adc_sample_t adc_sample_i,
  output logic [7:0]           sys_config_o,
  output bmc_pkg::chan_mask_t  in_range_o,
  output logic                 irq_o
);

  bmc_pkg::wb_req_t [`BMC_NUM_SLAVES-1:0] s_req;
  bmc_pkg::wb_rsp_t [`BMC_NUM_SLAVES-1:0] s_rsp;
  logic                                   memv;
  logic                                   viol_we;
  logic                                   lc_viol;
  bmc_pkg::addr_t                         viol_addr;

  // ========================================
  // slave-side decoder.
  // ========================================
  wb_decoder u_wb_decoder (
    .hard_reset  (hard_reset),
    .gclk40      (gclk40),
    .m_req_i     (wb_req_i),
    .m_rsp_o     (wb_rsp_o),
    .s_req_o     (s_req),
    .s_rsp_i     (s_rsp),
    .memv_o      (memv),
    .viol_addr_o (viol_addr),
    .viol_we_o   (viol_we)
  );

  // ========================================
  // register slaves.
  // ========================================
  sys_config u_sys_config (
    .hard_reset   (hard_reset),
    .gclk40       (gclk40),
    .req_i        (s_req[`BMC_SLV_SYSCONF]),
    .rsp_o        (s_rsp[`BMC_SLV_SYSCONF]),
    .sys_config_o (sys_config_o)
  );

  level_checker u_level_checker (
    .hard_reset   (hard_reset),
    .gclk40       (gclk40),
    .req_i        (s_req[`BMC_SLV_LEVCHK]),
    .rsp_o        (s_rsp[`BMC_SLV_LEVCHK]),
    .adc_sample_i (adc_sample_i),
    .in_range_o   (in_range_o),
    .viol_o       (lc_viol)
  );

  // source bit 0 is the level violation, bit 1 the memory violation.
  irq_controller u_irq_controller (
    .hard_reset (hard_reset),
    .gclk40     (gclk40),
    .req_i      (s_req[`BMC_SLV_IRQC]),
    .rsp_o      (s_rsp[`BMC_SLV_IRQC]),
    .src_i      ({memv, lc_viol}),
    .irq_o      (irq_o)
  );

  bus_monitor u_bus_monitor (
    .hard_reset  (hard_reset),
    .gclk40      (gclk40),
    .req_i       (s_req[`BMC_SLV_BUSMON]),
    .rsp_o       (s_rsp[`BMC_SLV_BUSMON]),
    .memv_i      (memv),
    .viol_addr_i (viol_addr),
    .viol_we_i   (viol_we)
  );

endmodule

// ==== tests/bmc_model.svh ====
// ========================================
// reference model of the register map.
// ========================================
logic [7:0]          m_cfg;
bmc_pkg::sample_t    m_thresh [`BMC_NUM_CHANNELS];
bmc_pkg::chan_mask_t m_in_range;
bmc_pkg::chan_mask_t m_sticky;
bmc_pkg::irq_vec_t   m_pending;
bmc_pkg::irq_vec_t   m_mask;
logic                m_cap_valid;
logic                m_cap_we;
bmc_pkg::addr_t      m_cap_addr;

task automatic model_reset();
  m_cfg = `BMC_SYSCFG_RESET;
  for (int i = 0; i < `BMC_NUM_CHANNELS; i++) begin
    m_thresh[i] = `BMC_THRESH_RESET;
  end
  m_in_range  = '1;
  m_sticky    = '0;
  m_pending   = '0;
  m_mask      = '0;
  m_cap_valid = 1'b0;
  m_cap_we    = 1'b0;
  m_cap_addr  = '0;
endtask

// slave index and offset of an address, slave -1 when it is unmapped.
task automatic model_decode(input bmc_pkg::addr_t adr, output int slv,
                            output bmc_pkg::addr_t ofs);
  bmc_pkg::addr_t base [`BMC_NUM_SLAVES];
  base = '{`BMC_SYSCONF_BASE, `BMC_LEVCHK_BASE, `BMC_IRQC_BASE, `BMC_BUSMON_BASE};
  slv  = -1;
  ofs  = adr;
  for (int i = 0; i < `BMC_NUM_SLAVES; i++) begin
    if (bmc_pkg::addr_t'(adr - base[i]) < bmc_pkg::addr_t'(`BMC_REGION_SIZE)) begin
      slv = i;
      ofs = adr - base[i];
    end
  end
endtask

// read data comes from the state before the write takes effect.
task automatic model_access(input logic we, input bmc_pkg::addr_t adr,
                            input bmc_pkg::data_t dat, output bmc_pkg::data_t rdat,
                            output logic err);
  int             slv;
  bmc_pkg::addr_t ofs;
  model_decode(adr, slv, ofs);
  rdat = '0;
  err  = (slv < 0);
  case (slv)
    `BMC_SLV_SYSCONF: begin
      if (ofs == `BMC_SYSCONF_ID_OFS) rdat = `BMC_BOARD_ID;
      if (ofs == `BMC_SYSCONF_REV_OFS) rdat = `BMC_REV;
      if (ofs == `BMC_SYSCONF_CFG_OFS) begin
        rdat = {8'h00, m_cfg};
        if (we) m_cfg = dat[7:0];
      end
    end
    `BMC_SLV_LEVCHK: begin
      if (ofs < bmc_pkg::addr_t'(`BMC_NUM_CHANNELS)) begin
        rdat = bmc_pkg::data_t'(m_thresh[ofs[2:0]]);
        if (we) m_thresh[ofs[2:0]] = bmc_pkg::sample_t'(dat);
      end
      if (ofs == `BMC_LEVCHK_INRANGE_OFS) rdat = bmc_pkg::data_t'(m_in_range);
      if (ofs == `BMC_LEVCHK_STICKY_OFS) begin
        rdat = bmc_pkg::data_t'(m_sticky);
        if (we) m_sticky = m_sticky & ~bmc_pkg::chan_mask_t'(dat);
      end
    end
    `BMC_SLV_IRQC: begin
      if (ofs == `BMC_IRQC_PENDING_OFS) begin
        rdat = bmc_pkg::data_t'(m_pending);
        if (we) m_pending = m_pending & ~bmc_pkg::irq_vec_t'(dat);
      end
      if (ofs == `BMC_IRQC_MASK_OFS) begin
        rdat = bmc_pkg::data_t'(m_mask);
        if (we) m_mask = bmc_pkg::irq_vec_t'(dat);
      end
    end
    `BMC_SLV_BUSMON: begin
      if (ofs == `BMC_BUSMON_ADDR_OFS) rdat = m_cap_addr;
      if (ofs == `BMC_BUSMON_STATUS_OFS) begin
        rdat = {14'h0000, m_cap_we, m_cap_valid};
        if (we) m_cap_valid = 1'b0;
      end
    end
    default: begin
      // memory violation, bit 1 of pending.
      m_pending[1] = 1'b1;
      if (!m_cap_valid) begin
        m_cap_valid = 1'b1;
        m_cap_we    = we;
        m_cap_addr  = adr;
      end
    end
  endcase
endtask

task automatic model_sample(input bmc_pkg::chan_t ch, input bmc_pkg::sample_t res);
  logic over;
  over           = res > m_thresh[ch];
  m_in_range[ch] = !over;
  if (over) begin
    m_sticky[ch] = 1'b1;
    m_pending[0] = 1'b1;
  end
endtask

// ==== tests/tb_bmc.sv ====
`include "bmc_macros.svh"

module tb_bmc;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SEED         = 32'h10837e97;
  localparam int N_CFG_ROUNDS = 8;
  localparam int N_SAMPLES    = 300;
  localparam int N_UNMAPPED   = 6;
  localparam int N_ACCESSES   = 5 + 4 * N_CFG_ROUNDS + 2 * `BMC_NUM_CHANNELS + 1 + 7 + 7 +
                                N_UNMAPPED + 8;
  localparam int CYCLE_LIMIT  = (N_ACCESSES + N_SAMPLES + 2) * 4 + 200;

  localparam bmc_pkg::addr_t ID_ADR      = `BMC_SYSCONF_BASE + `BMC_SYSCONF_ID_OFS;
  localparam bmc_pkg::addr_t REV_ADR     = `BMC_SYSCONF_BASE + `BMC_SYSCONF_REV_OFS;
  localparam bmc_pkg::addr_t CFG_ADR     = `BMC_SYSCONF_BASE + `BMC_SYSCONF_CFG_OFS;
  localparam bmc_pkg::addr_t INRANGE_ADR = `BMC_LEVCHK_BASE + `BMC_LEVCHK_INRANGE_OFS;
  localparam bmc_pkg::addr_t STICKY_ADR  = `BMC_LEVCHK_BASE + `BMC_LEVCHK_STICKY_OFS;
  localparam bmc_pkg::addr_t PENDING_ADR = `BMC_IRQC_BASE + `BMC_IRQC_PENDING_OFS;
  localparam bmc_pkg::addr_t MASK_ADR    = `BMC_IRQC_BASE + `BMC_IRQC_MASK_OFS;
  localparam bmc_pkg::addr_t CAP_ADR     = `BMC_BUSMON_BASE + `BMC_BUSMON_ADDR_OFS;
  localparam bmc_pkg::addr_t STATUS_ADR  = `BMC_BUSMON_BASE + `BMC_BUSMON_STATUS_OFS;

  logic                 gclk40;
  logic                 hard_reset;
  bmc_pkg::wb_req_t     wb_req;
  bmc_pkg::wb_rsp_t     wb_rsp;
  bmc_pkg::adc_sample_t adc_sample;
  logic [7:0]           sys_config;
  bmc_pkg::chan_mask_t  in_range;
  logic                 irq;
  int                   errors = 0;
  int                   checks = 0;
  int                   cycles = 0;

  `include "bmc_model.svh"

  bmc_top dut (
    .hard_reset   (hard_reset),
    .gclk40       (gclk40),
    .wb_req_i     (wb_req),
    .wb_rsp_o     (wb_rsp),
    .adc_sample_i (adc_sample),
    .sys_config_o (sys_config),
    .in_range_o   (in_range),
    .irq_o        (irq)
  );

  initial begin
    gclk40 = 1'b0;
    forever #20 gclk40 = ~gclk40;
  end

  always @(posedge gclk40) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ========================================
  // check and bus helpers.
  // ========================================
  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // one classic cycle, stb held until ack or err, then dropped.
  task automatic bus_access(input logic we, input bmc_pkg::addr_t adr,
                            input bmc_pkg::data_t dat, output bmc_pkg::data_t rdat,
                            output logic ack, output logic err);
    int waited;
    @(posedge gclk40);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    waited = 0;
    do begin
      @(negedge gclk40);
      waited++;
    end while (!(wb_rsp.ack || wb_rsp.err) && waited < 8);
    ack  = wb_rsp.ack;
    err  = wb_rsp.err;
    rdat = wb_rsp.dat;
    assert (ack || err) else begin
      $display("bus access to %h got neither ack nor err", adr);
      errors++;
    end
    @(posedge gclk40);
    wb_req <= '0;
  endtask

  task automatic access_check(input logic we, input bmc_pkg::addr_t adr,
                              input bmc_pkg::data_t dat);
    bmc_pkg::data_t exp_dat;
    bmc_pkg::data_t got_dat;
    logic           exp_err;
    logic           got_ack;
    logic           got_err;
    model_access(we, adr, dat, exp_dat, exp_err);
    bus_access(we, adr, dat, got_dat, got_ack, got_err);
    check_value($sformatf("wb_rsp_o.err @%h", adr), 16'(got_err), 16'(exp_err));
    check_value($sformatf("wb_rsp_o.ack @%h", adr), 16'(got_ack), 16'(!exp_err));
    if (!we && !exp_err) begin
      check_value($sformatf("wb_rsp_o.dat @%h", adr), got_dat, exp_dat);
    end
  endtask

  task automatic reg_write(input bmc_pkg::addr_t adr, input bmc_pkg::data_t dat);
    access_check(1'b1, adr, dat);
  endtask

  task automatic reg_read(input bmc_pkg::addr_t adr);
    access_check(1'b0, adr, '0);
  endtask

  task automatic unmapped_access();
    bmc_pkg::addr_t adr;
    bmc_pkg::addr_t ofs;
    int             slv;
    do begin
      adr = bmc_pkg::addr_t'($urandom);
      model_decode(adr, slv, ofs);
    end while (slv >= 0);
    access_check(1'($urandom), adr, bmc_pkg::data_t'($urandom));
  endtask

  task automatic drive_sample(input bmc_pkg::chan_t ch, input bmc_pkg::sample_t res);
    @(posedge gclk40);
    adc_sample <= '{valid: 1'b1, channel: ch, result: res};
    @(posedge gclk40);
    adc_sample <= '0;
    model_sample(ch, res);
    @(negedge gclk40);
    check_value("in_range_o", 16'(in_range), 16'(m_in_range));
  endtask

  // pending settles one cycle after its source, irq_o one more.
  task automatic check_irq();
    repeat (2) @(posedge gclk40);
    @(negedge gclk40);
    check_value("irq_o", 16'(irq), 16'(|(m_pending & m_mask)));
  endtask

  // ========================================
  // test sequence.
  // ========================================
  initial begin
    void'($urandom(SEED));
    hard_reset = 1'b0;
    wb_req     = '0;
    adc_sample = '0;
    model_reset();
    repeat (16) @(posedge gclk40);
    hard_reset <= 1'b1;

    // identity and configuration.
    @(negedge gclk40);
    check_value("sys_config_o", 16'(sys_config), 16'(m_cfg));
    check_value("irq_o", 16'(irq), 16'h0000);
    check_value("in_range_o", 16'(in_range), 16'(m_in_range));
    reg_read(ID_ADR);
    reg_read(REV_ADR);
    reg_read(CFG_ADR);
    for (int r = 0; r < N_CFG_ROUNDS; r++) begin
      reg_write(CFG_ADR, bmc_pkg::data_t'($urandom));
      @(negedge gclk40);
      check_value("sys_config_o", 16'(sys_config), 16'(m_cfg));
      reg_read(CFG_ADR);
      reg_write(ID_ADR, bmc_pkg::data_t'($urandom));
      reg_write(REV_ADR, bmc_pkg::data_t'($urandom));
    end
    reg_read(ID_ADR);
    reg_read(REV_ADR);

    // thresholds, then random samples.
    for (int i = 0; i < `BMC_NUM_CHANNELS; i++) begin
      reg_write(`BMC_LEVCHK_BASE + 16'(i), bmc_pkg::data_t'($urandom));
      reg_read(`BMC_LEVCHK_BASE + 16'(i));
    end
    for (int s = 0; s < N_SAMPLES; s++) begin
      drive_sample(bmc_pkg::chan_t'($urandom), bmc_pkg::sample_t'($urandom));
    end
    reg_read(INRANGE_ADR);

    // sticky violations, partial clears.
    for (int k = 0; k < 2; k++) begin
      reg_read(STICKY_ADR);
      reg_write(STICKY_ADR, bmc_pkg::data_t'($urandom & 32'h00ff));
      reg_read(STICKY_ADR);
    end
    reg_write(STICKY_ADR, 16'h00ff);

    // interrupt line against mask and pending.
    check_irq();
    reg_write(MASK_ADR, 16'h0001);
    check_irq();
    reg_read(PENDING_ADR);
    reg_write(PENDING_ADR, 16'h0001);
    check_irq();
    reg_write(`BMC_LEVCHK_BASE, 16'h0000);
    drive_sample(3'd0, bmc_pkg::sample_t'($urandom) | 12'h001);
    check_irq();
    reg_read(PENDING_ADR);
    reg_write(MASK_ADR, 16'h0000);
    check_irq();
    drive_sample(3'd0, bmc_pkg::sample_t'($urandom) | 12'h001);
    check_irq();
    reg_write(PENDING_ADR, 16'h0003);

    // unmapped accesses and the bus monitor capture.
    for (int u = 0; u < N_UNMAPPED; u++) begin
      unmapped_access();
    end
    reg_read(PENDING_ADR);
    reg_read(CAP_ADR);
    reg_read(STATUS_ADR);
    reg_write(STATUS_ADR, 16'h0000);
    reg_read(STATUS_ADR);
    unmapped_access();
    reg_read(CAP_ADR);
    reg_read(STATUS_ADR);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+logic
+incdir+tests
logic/bmc_pkg.sv
logic/wb_decoder.sv
logic/sys_config.sv
logic/level_checker.sv
logic/irq_controller.sv
logic/bus_monitor.sv
logic/bmc_top.sv
tests/tb_bmc.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_bmc -f sim.f -o tb_bmc

out=$(./obj_dir/tb_bmc)
echo "$out"
echo "$out" | grep -qx "ALL TESTS PASSED"
